/* common/resp_buf_pkg.sv */
`default_nettype none

package resp_buf_pkg;

    // Width of a transaction ID as carried in the command payload
    localparam int ID_WIDTH = 3;

    // Width of one stored response datum
    localparam int DATA_WIDTH = 8;

    // The command payload is one word; the opcode decides how it is read
    localparam int PAYLOAD_WIDTH = 16;

    localparam int OP_WIDTH = 2;
    localparam int ST_WIDTH = 2;

    // Append a datum to the FIFO of an ID
    localparam logic [OP_WIDTH-1:0] OP_PUSH = 2'd0;
    // Return the oldest datum of an ID and leave it stored
    localparam logic [OP_WIDTH-1:0] OP_READ = 2'd1;
    // Return the oldest datum of an ID and remove it
    localparam logic [OP_WIDTH-1:0] OP_POP = 2'd2;
    // Look for any stored datum that equals a pattern on the masked bits
    localparam logic [OP_WIDTH-1:0] OP_SEARCH = 2'd3;

    localparam logic [ST_WIDTH-1:0] ST_OK = 2'd0;
    // Used both for an absent ID and for a search without a hit
    localparam logic [ST_WIDTH-1:0] ST_NOT_FOUND = 2'd1;
    localparam logic [ST_WIDTH-1:0] ST_FULL = 2'd2;

    // Command payload with two views of the same 16 bits
    // Push, read and pop use the entry view; read and pop ignore its data field
    // Search uses the search view, with the mask in the upper byte
    typedef union packed {
        struct packed {
            logic [ID_WIDTH-1:0]                          id;
            logic [PAYLOAD_WIDTH-ID_WIDTH-DATA_WIDTH-1:0] unused;
            logic [DATA_WIDTH-1:0]                        data;
        } entry;
        struct packed {
            logic [DATA_WIDTH-1:0] mask;
            logic [DATA_WIDTH-1:0] pattern;
        } search;
    } cmd_payload_u;

endpackage

`default_nettype wire

/* id_queue/first_free_finder.sv */
`timescale 1ns/1ps
`default_nettype none

module first_free_finder #(
    parameter  int WIDTH     = 4,
    // Index width, kept at one bit for a single-entry table
    localparam int IDX_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0]     free_i,
    output logic [IDX_WIDTH-1:0] idx_o,
    output logic                 any_o
);

    // Scan from the top down so that the lowest set bit is written last and wins
    // With no bit set the index stays zero and any_o tells the caller to ignore it
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IDX_WIDTH'(i);
            end
        end
    end

    assign any_o = |free_i;

endmodule

`default_nettype wire

/* id_queue/id_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module id_queue #(
    parameter int CAPACITY = 6
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [resp_buf_pkg::ID_WIDTH-1:0]   inp_id_i,
    input  logic [resp_buf_pkg::DATA_WIDTH-1:0] inp_data_i,
    input  logic                                inp_req_i,
    output logic                                inp_gnt_o,
    input  logic [resp_buf_pkg::DATA_WIDTH-1:0] exists_data_i,
    input  logic [resp_buf_pkg::DATA_WIDTH-1:0] exists_mask_i,
    input  logic                                exists_req_i,
    output logic                                exists_o,
    input  logic [resp_buf_pkg::ID_WIDTH-1:0]   oup_id_i,
    input  logic                                oup_pop_i,
    input  logic                                oup_req_i,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] oup_data_o,
    output logic                                oup_data_valid_o
);

    localparam int N_IDS = 2 ** resp_buf_pkg::ID_WIDTH;
    // There can never be more active IDs than stored entries
    localparam int HT_CAPACITY = (N_IDS <= CAPACITY) ? N_IDS : CAPACITY;
    localparam int HT_IDX_WIDTH = (HT_CAPACITY > 1) ? $clog2(HT_CAPACITY) : 1;
    localparam int LD_IDX_WIDTH = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;

    // Head-tail table, one row per active ID
    // A free row holds no ID and its other fields are meaningless
    logic [resp_buf_pkg::ID_WIDTH-1:0] ht_id_q   [HT_CAPACITY];
    logic [resp_buf_pkg::ID_WIDTH-1:0] ht_id_d   [HT_CAPACITY];
    logic [LD_IDX_WIDTH-1:0]           ht_head_q [HT_CAPACITY];
    logic [LD_IDX_WIDTH-1:0]           ht_head_d [HT_CAPACITY];
    logic [LD_IDX_WIDTH-1:0]           ht_tail_q [HT_CAPACITY];
    logic [LD_IDX_WIDTH-1:0]           ht_tail_d [HT_CAPACITY];
    logic [HT_CAPACITY-1:0]            ht_free_q;
    logic [HT_CAPACITY-1:0]            ht_free_d;

    // Linked data table shared by all IDs, each entry points to the next one of its ID
    logic [resp_buf_pkg::DATA_WIDTH-1:0] ld_data_q [CAPACITY];
    logic [resp_buf_pkg::DATA_WIDTH-1:0] ld_data_d [CAPACITY];
    logic [LD_IDX_WIDTH-1:0]             ld_next_q [CAPACITY];
    logic [LD_IDX_WIDTH-1:0]             ld_next_d [CAPACITY];
    logic [CAPACITY-1:0]                 ld_free_q;
    logic [CAPACITY-1:0]                 ld_free_d;

    logic [resp_buf_pkg::ID_WIDTH-1:0] match_id;
    logic [HT_CAPACITY-1:0]            idx_matches_id;
    logic [HT_IDX_WIDTH-1:0]           match_idx;
    logic                              no_id_match;
    logic [HT_IDX_WIDTH-1:0]           ht_free_idx;
    logic [LD_IDX_WIDTH-1:0]           ld_free_idx;
    logic                              ld_any_free;
    logic [LD_IDX_WIDTH-1:0]           oup_head;
    logic [LD_IDX_WIDTH-1:0]           oup_tail;
    logic [CAPACITY-1:0]               exists_match;

    // The decoder never raises push and read together, so one ID lookup serves both ports
    assign match_id = inp_req_i ? inp_id_i : oup_id_i;

    for (genvar i = 0; i < HT_CAPACITY; i++) begin : gen_idx_match
        assign idx_matches_id[i] = !ht_free_q[i] && (ht_id_q[i] == match_id);
    end
    assign no_id_match = ~|idx_matches_id;

    // An ID is held in at most one row, so the match vector is one-hot or zero
    // ORing the indices of set bits turns it into a binary row number
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < HT_CAPACITY; i++) begin
            if (idx_matches_id[i]) begin
                match_idx = match_idx | HT_IDX_WIDTH'(i);
            end
        end
    end

    // Row for a newly seen ID
    // A free row always exists while the data table has room, so its any flag is not needed
    first_free_finder #(
        .WIDTH (HT_CAPACITY)
    ) i_ht_free (
        .free_i (ht_free_q),
        .idx_o  (ht_free_idx),
        .any_o  ()
    );

    // Entry for a new datum; no free entry at all means the queue is full
    first_free_finder #(
        .WIDTH (CAPACITY)
    ) i_ld_free (
        .free_i (ld_free_q),
        .idx_o  (ld_free_idx),
        .any_o  (ld_any_free)
    );

    assign inp_gnt_o = ld_any_free;

    // Head and tail of the ID being read, valid only when the ID was found
    assign oup_head = ht_head_q[match_idx];
    assign oup_tail = ht_tail_q[match_idx];

    always_comb begin
        ht_id_d          = ht_id_q;
        ht_head_d        = ht_head_q;
        ht_tail_d        = ht_tail_q;
        ht_free_d        = ht_free_q;
        ld_data_d        = ld_data_q;
        ld_next_d        = ld_next_q;
        ld_free_d        = ld_free_q;
        oup_data_o       = '0;
        oup_data_valid_o = 1'b0;
        if (inp_req_i && ld_any_free) begin
            if (no_id_match) begin
                // First datum of this ID starts a one-entry list
                ht_id_d[ht_free_idx]   = inp_id_i;
                ht_head_d[ht_free_idx] = ld_free_idx;
                ht_tail_d[ht_free_idx] = ld_free_idx;
                ht_free_d[ht_free_idx] = 1'b0;
            end else begin
                // Link the old tail to the new entry and move the tail
                ld_next_d[ht_tail_q[match_idx]] = ld_free_idx;
                ht_tail_d[match_idx]            = ld_free_idx;
            end
            ld_data_d[ld_free_idx] = inp_data_i;
            ld_next_d[ld_free_idx] = '0;
            ld_free_d[ld_free_idx] = 1'b0;
        end else if (oup_req_i && !no_id_match) begin
            oup_data_o       = ld_data_q[oup_head];
            oup_data_valid_o = 1'b1;
            if (oup_pop_i) begin
                ld_free_d[oup_head] = 1'b1;
                // Removing the last datum of an ID releases its row as well
                if (oup_head == oup_tail) begin
                    ht_free_d[match_idx] = 1'b1;
                end else begin
                    ht_head_d[match_idx] = ld_next_q[oup_head];
                end
            end
        end
    end

    // A bit with a zero mask always compares equal, so a zero mask hits any occupied entry
    for (genvar i = 0; i < CAPACITY; i++) begin : gen_lookup
        assign exists_match[i] = !ld_free_q[i] &&
                                 (((ld_data_q[i] ^ exists_data_i) & exists_mask_i) == '0);
    end
    assign exists_o = exists_req_i && (|exists_match);

    // Only the free flags decide what the tables hold, so only they are reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ht_free_q <= '1;
            ld_free_q <= '1;
        end else begin
            ht_free_q <= ht_free_d;
            ld_free_q <= ld_free_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ht_id_q   <= ht_id_d;
        ht_head_q <= ht_head_d;
        ht_tail_q <= ht_tail_d;
        ld_data_q <= ld_data_d;
        ld_next_q <= ld_next_d;
    end

endmodule

`default_nettype wire

/* design/cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               cmd_valid_i,
    input  logic [resp_buf_pkg::OP_WIDTH-1:0]  cmd_op_i,
    input  resp_buf_pkg::cmd_payload_u         cmd_payload_i,
    output logic                               push_req_o,
    output logic                               read_req_o,
    output logic                               pop_o,
    output logic                               search_req_o,
    output logic [resp_buf_pkg::ID_WIDTH-1:0]   id_o,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] data_o,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] search_data_o,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] search_mask_o,
    output logic [resp_buf_pkg::OP_WIDTH-1:0]  op_o,
    output logic                               valid_o
);

    // Request strobes and the valid bit are control state and are cleared on reset
    // Exactly one strobe follows each accepted command, and none in an idle cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o      <= 1'b0;
            push_req_o   <= 1'b0;
            read_req_o   <= 1'b0;
            pop_o        <= 1'b0;
            search_req_o <= 1'b0;
        end else begin
            valid_o      <= cmd_valid_i;
            push_req_o   <= cmd_valid_i && (cmd_op_i == resp_buf_pkg::OP_PUSH);
            // Read and pop share the output port of the queue
            read_req_o   <= cmd_valid_i && ((cmd_op_i == resp_buf_pkg::OP_READ) ||
                                            (cmd_op_i == resp_buf_pkg::OP_POP));
            // Pop only qualifies the read request, it is never high on its own
            pop_o        <= cmd_valid_i && (cmd_op_i == resp_buf_pkg::OP_POP);
            search_req_o <= cmd_valid_i && (cmd_op_i == resp_buf_pkg::OP_SEARCH);
        end
    end

    // Field registers hold payload only and load with each accepted command
    // The strobes above tell the queue which of them are meaningful
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            op_o <= cmd_op_i;
            case (cmd_op_i)
                resp_buf_pkg::OP_SEARCH: begin
                    // Search word: mask on top, pattern below
                    search_data_o <= cmd_payload_i.search.pattern;
                    search_mask_o <= cmd_payload_i.search.mask;
                end
                default: begin
                    // Push, read and pop all carry an ID in the entry view
                    id_o   <= cmd_payload_i.entry.id;
                    data_o <= cmd_payload_i.entry.data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/resp_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_formatter (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                valid_i,
    input  logic [resp_buf_pkg::OP_WIDTH-1:0]   op_i,
    input  logic                                push_gnt_i,
    input  logic [resp_buf_pkg::DATA_WIDTH-1:0] read_data_i,
    input  logic                                read_valid_i,
    input  logic                                exists_i,
    output logic                                resp_valid_o,
    output logic [resp_buf_pkg::OP_WIDTH-1:0]   resp_op_o,
    output logic [resp_buf_pkg::ST_WIDTH-1:0]   resp_status_o,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] resp_data_o
);

    logic [resp_buf_pkg::ST_WIDTH-1:0]   status;
    logic [resp_buf_pkg::DATA_WIDTH-1:0] data;

    // Status depends on the opcode of the command now in the execute stage
    always_comb begin
        case (op_i)
            resp_buf_pkg::OP_PUSH: begin
                status = push_gnt_i ? resp_buf_pkg::ST_OK : resp_buf_pkg::ST_FULL;
            end
            resp_buf_pkg::OP_SEARCH: begin
                status = exists_i ? resp_buf_pkg::ST_OK : resp_buf_pkg::ST_NOT_FOUND;
            end
            default: begin
                // Read and pop
                status = read_valid_i ? resp_buf_pkg::ST_OK : resp_buf_pkg::ST_NOT_FOUND;
            end
        endcase
    end

    // Only a read or pop that found its ID returns data, every other response is zero
    // The queue already drives zero data when the ID was absent
    always_comb begin
        data = '0;
        if ((op_i == resp_buf_pkg::OP_READ) || (op_i == resp_buf_pkg::OP_POP)) begin
            data = read_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= valid_i;
        end
    end

    // Response fields are only looked at while resp_valid_o is high
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            resp_op_o     <= op_i;
            resp_status_o <= status;
            resp_data_o   <= data;
        end
    end

endmodule

`default_nettype wire

/* design/resp_buf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_buf_top #(
    parameter int CAPACITY = 6
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                cmd_valid_i,
    input  logic [resp_buf_pkg::OP_WIDTH-1:0]   cmd_op_i,
    input  resp_buf_pkg::cmd_payload_u          cmd_payload_i,
    output logic                                resp_valid_o,
    output logic [resp_buf_pkg::OP_WIDTH-1:0]   resp_op_o,
    output logic [resp_buf_pkg::ST_WIDTH-1:0]   resp_status_o,
    output logic [resp_buf_pkg::DATA_WIDTH-1:0] resp_data_o
);

    // Decode stage outputs
    logic                                push_req;
    logic                                read_req;
    logic                                pop;
    logic                                search_req;
    logic [resp_buf_pkg::ID_WIDTH-1:0]   id;
    logic [resp_buf_pkg::DATA_WIDTH-1:0] data;
    logic [resp_buf_pkg::DATA_WIDTH-1:0] search_data;
    logic [resp_buf_pkg::DATA_WIDTH-1:0] search_mask;
    logic [resp_buf_pkg::OP_WIDTH-1:0]   dec_op;
    logic                                dec_valid;

    // Execute stage results, combinational from the queue
    logic                                push_gnt;
    logic [resp_buf_pkg::DATA_WIDTH-1:0] read_data;
    logic                                read_valid;
    logic                                exists;

    cmd_decoder i_decoder (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_op_i      (cmd_op_i),
        .cmd_payload_i (cmd_payload_i),
        .push_req_o    (push_req),
        .read_req_o    (read_req),
        .pop_o         (pop),
        .search_req_o  (search_req),
        .id_o          (id),
        .data_o        (data),
        .search_data_o (search_data),
        .search_mask_o (search_mask),
        .op_o          (dec_op),
        .valid_o       (dec_valid)
    );

    // One decoded ID feeds both the push and the read port of the queue
    id_queue #(
        .CAPACITY (CAPACITY)
    ) i_queue (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (id),
        .inp_data_i       (data),
        .inp_req_i        (push_req),
        .inp_gnt_o        (push_gnt),
        .exists_data_i    (search_data),
        .exists_mask_i    (search_mask),
        .exists_req_i     (search_req),
        .exists_o         (exists),
        .oup_id_i         (id),
        .oup_pop_i        (pop),
        .oup_req_i        (read_req),
        .oup_data_o       (read_data),
        .oup_data_valid_o (read_valid)
    );

    resp_formatter i_formatter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .valid_i       (dec_valid),
        .op_i          (dec_op),
        .push_gnt_i    (push_gnt),
        .read_data_i   (read_data),
        .read_valid_i  (read_valid),
        .exists_i      (exists),
        .resp_valid_o  (resp_valid_o),
        .resp_op_o     (resp_op_o),
        .resp_status_o (resp_status_o),
        .resp_data_o   (resp_data_o)
    );

endmodule

`default_nettype wire

/* verif/resp_buf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_buf_tb;

    localparam int CAPACITY      = 6;
    localparam int CLK_PERIOD    = 100;
    // The watchdog budget allows at most this many directed commands
    localparam int DIRECTED_CMDS = 60;
    localparam int RANDOM_CMDS   = 300;
    localparam int TIMEOUT_NS    = (DIRECTED_CMDS + RANDOM_CMDS) * CLK_PERIOD + 20 * CLK_PERIOD;

    logic                              clk_i;
    logic                              rst_ni;
    logic                              cmd_valid_i;
    logic [resp_buf_pkg::OP_WIDTH-1:0] cmd_op_i;
    resp_buf_pkg::cmd_payload_u        cmd_payload_i;
    logic                              resp_valid_o;
    logic [1:0]                        resp_op_o;
    logic [1:0]                        resp_status_o;
    logic [7:0]                        resp_data_o;

    // Model contents in arrival order with each entry packed as {id, data}
    logic [10:0] model_q [$];
    // Expected responses in command order with each entry packed as {op, status, data}
    logic [11:0] exp_q [$];
    // Number of the rising edge that samples each pending command
    int          sampled_q [$];
    logic [11:0] expected;
    int          sampled;
    int          cycle;
    int          errors;
    int          checks;
    int          wait_cycles;
    logic [31:0] r;
    logic [1:0]  rand_op;

    resp_buf_top #(
        .CAPACITY (CAPACITY)
    ) UUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_op_i      (cmd_op_i),
        .cmd_payload_i (cmd_payload_i),
        .resp_valid_o  (resp_valid_o),
        .resp_op_o     (resp_op_o),
        .resp_status_o (resp_status_o),
        .resp_data_o   (resp_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Returns the expected response of one command and updates the model as the buffer would
    // The oldest model entry with a matching ID is the head of that ID
    function automatic logic [11:0] predict(input logic [1:0] op, input logic [2:0] id,
                                            input logic [7:0] data, input logic [7:0] mask,
                                            input logic [7:0] pattern);
        logic [1:0] st;
        logic [7:0] rdata;
        int         pos;
        int         i;
        st    = resp_buf_pkg::ST_NOT_FOUND;
        rdata = 8'h00;
        pos   = -1;
        if (op == resp_buf_pkg::OP_PUSH) begin
            if (model_q.size() < CAPACITY) begin
                model_q.push_back({id, data});
                st = resp_buf_pkg::ST_OK;
            end else begin
                st = resp_buf_pkg::ST_FULL;
            end
        end else if (op == resp_buf_pkg::OP_SEARCH) begin
            // Bits outside the mask never count against a match
            for (i = 0; i < model_q.size(); i++) begin
                if ((model_q[i][7:0] & mask) == (pattern & mask)) begin
                    st = resp_buf_pkg::ST_OK;
                end
            end
        end else begin
            for (i = 0; i < model_q.size(); i++) begin
                if (pos < 0 && model_q[i][10:8] == id) begin
                    pos = i;
                end
            end
            if (pos >= 0) begin
                st    = resp_buf_pkg::ST_OK;
                rdata = model_q[pos][7:0];
                if (op == resp_buf_pkg::OP_POP) begin
                    model_q.delete(pos);
                end
            end
        end
        return {op, st, rdata};
    endfunction

    task automatic compare(input string field, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, field, got, exp);
            errors++;
        end
    endtask

    // Drives one command on the falling edge and queues its expected response
    task automatic send_cmd(input logic [1:0] op, input logic [2:0] id, input logic [7:0] data,
                            input logic [4:0] filler, input logic [7:0] mask,
                            input logic [7:0] pattern);
        @(negedge clk_i);
        cmd_valid_i = 1'b1;
        cmd_op_i    = op;
        if (op == resp_buf_pkg::OP_SEARCH) begin
            cmd_payload_i.search.mask    = mask;
            cmd_payload_i.search.pattern = pattern;
        end else begin
            cmd_payload_i.entry.id     = id;
            cmd_payload_i.entry.unused = filler;
            cmd_payload_i.entry.data   = data;
        end
        exp_q.push_back(predict(op, id, data, mask, pattern));
        // The next rising edge samples this command
        sampled_q.push_back(cycle + 1);
    endtask

    task automatic push_entry(input logic [2:0] id, input logic [7:0] data);
        send_cmd(resp_buf_pkg::OP_PUSH, id, data, 5'h00, 8'h00, 8'h00);
    endtask

    task automatic read_head(input logic [2:0] id);
        send_cmd(resp_buf_pkg::OP_READ, id, 8'h00, 5'h00, 8'h00, 8'h00);
    endtask

    task automatic pop_head(input logic [2:0] id);
        send_cmd(resp_buf_pkg::OP_POP, id, 8'h00, 5'h00, 8'h00, 8'h00);
    endtask

    task automatic search_for(input logic [7:0] mask, input logic [7:0] pattern);
        send_cmd(resp_buf_pkg::OP_SEARCH, 3'd0, 8'h00, 5'h00, mask, pattern);
    endtask

    // Each valid response retires the oldest expectation
    // A response is due two rising edges after the edge that sampled its command
    always @(posedge clk_i) begin
        cycle++;
        if (rst_ni && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: a response arrived with no command pending", $time);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                sampled  = sampled_q.pop_front();
                compare("latency", 8'(cycle - sampled), 8'd2);
                compare("op", 8'(resp_op_o), 8'(expected[11:10]));
                compare("status", 8'(resp_status_o), 8'(expected[9:8]));
                compare("data", resp_data_o, expected[7:0]);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        errors        = 0;
        checks        = 0;
        cycle         = 0;
        rst_ni        = 1'b0;
        cmd_valid_i   = 1'b0;
        cmd_op_i      = '0;
        cmd_payload_i = '0;
        void'($urandom(32'h1536));
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Interleaved pushes to three IDs fill the buffer and then each ID drains in order
        for (int i = 0; i < 6; i++) begin
            push_entry(3'(1 + i % 3), 8'(8'h10 + i));
        end
        for (int i = 0; i < 6; i++) begin
            pop_head(3'(3 - i / 2));
        end

        // Read twice without removing and then pop the same head and the one behind it
        push_entry(3'd4, 8'hA1);
        push_entry(3'd4, 8'hA2);
        read_head(3'd4);
        read_head(3'd4);
        pop_head(3'd4);
        pop_head(3'd4);

        // IDs with nothing stored
        read_head(3'd5);
        pop_head(3'd5);
        pop_head(3'd4);

        // Fill to capacity, overflow once, free one entry and push again
        for (int i = 0; i < 6; i++) begin
            push_entry(3'(i % 3), 8'(8'h40 + i));
        end
        push_entry(3'd3, 8'h46);
        pop_head(3'd0);
        push_entry(3'd0, 8'h47);
        pop_head(3'd0);
        pop_head(3'd0);

        // Left stored are 41, 44, 42 and 45
        search_for(8'hF0, 8'h40);
        search_for(8'h0F, 8'h03);
        search_for(8'h0F, 8'h05);
        search_for(8'hFF, 8'h99);
        search_for(8'h00, 8'h77);
        pop_head(3'd1);
        pop_head(3'd1);
        pop_head(3'd2);
        pop_head(3'd2);
        // Zero mask on an empty buffer finds nothing
        search_for(8'h00, 8'h77);

        // Random back-to-back traffic is biased toward pushes so the buffer fills up
        for (int k = 0; k < RANDOM_CMDS; k++) begin
            r = $urandom;
            case (r[2:0])
                3'd0, 3'd1, 3'd2: rand_op = resp_buf_pkg::OP_PUSH;
                3'd3:             rand_op = resp_buf_pkg::OP_READ;
                3'd4, 3'd5:       rand_op = resp_buf_pkg::OP_POP;
                default:          rand_op = resp_buf_pkg::OP_SEARCH;
            endcase
            send_cmd(rand_op, r[5:3], r[13:6], r[18:14], r[23:16], r[31:24]);
        end

        @(negedge clk_i);
        cmd_valid_i = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        // A few idle cycles catch any response that has no command behind it
        repeat (3) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected responses never arrived", exp_q.size());
            errors += exp_q.size();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
common/resp_buf_pkg.sv
id_queue/first_free_finder.sv
id_queue/id_queue.sv
design/cmd_decoder.sv
design/resp_formatter.sv
design/resp_buf_top.sv
verif/resp_buf_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run; the exit status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module resp_buf_tb -o resp_buf_sim || exit 1
out=$(./obj_dir/resp_buf_sim)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
